/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_npc_mem
FILELIST  ?= npc_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axi_sram.sv */
`default_nettype none
`timescale 1ns/1ps

`include "npc_mem_params.svh"

module axi_sram import npc_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  mem_addr_t ar,
	input  logic      ar_valid,
	output logic      ar_ready,
	output mem_r_t    r,
	output logic      r_valid,
	input  logic      r_ready,
	input  mem_addr_t aw,
	input  logic      aw_valid,
	output logic      aw_ready,
	input  mem_w_t    w,
	input  logic      w_valid,
	output logic      w_ready,
	output mem_b_t    b,
	output logic      b_valid,
	input  logic      b_ready
);

	localparam int STRB_W = `NPC_DATA_W / 8;
	localparam int OFS_W  = $clog2(STRB_W);
	// word index as carried by the address
	localparam int IDX_W  = `NPC_ADDR_W - OFS_W;
	// word index into the array
	localparam int MEM_AW = $clog2(`NPC_SRAM_WORDS);

	typedef enum logic [1:0] {
		SRAM_IDLE,
		SRAM_READ,
		SRAM_WRITE,
		SRAM_RESP
	} sram_state_t;

	logic [`NPC_DATA_W-1:0] mem [`NPC_SRAM_WORDS];

	sram_state_t      state;
	// current beat word and beats still to go after it
	logic [IDX_W-1:0] idx_q;
	logic [7:0]       cnt_q;
	// burst type not supported
	logic             bad_q;
	// sticky error over a write burst
	logic             err_q;
	mem_addr_t        req;
	logic             req_bad;
	logic             beat_ok;
	logic             r_fire;
	logic             w_fire;

	// ****************************************
	// request select and handshakes
	// ****************************************

	// write wins when both wait in idle
	assign req      = aw_valid ? aw : ar;
	assign req_bad  = (req.size != SIZE_8B) || (req.burst != BURST_INCR);
	assign ar_ready = (state == SRAM_IDLE) && !aw_valid;
	assign aw_ready = state == SRAM_IDLE;
	assign w_ready  = state == SRAM_WRITE;
	assign r_valid  = state == SRAM_READ;
	assign b_valid  = state == SRAM_RESP;
	assign r_fire   = r_valid && r_ready;
	assign w_fire   = w_valid && w_ready;

	// per beat range check
	assign beat_ok = (idx_q < IDX_W'(`NPC_SRAM_WORDS)) && !bad_q;

	// read beat comes straight from the array at the held index
	always_comb begin
		r.data = beat_ok ? mem[idx_q[MEM_AW-1:0]] : '0;
		r.resp = beat_ok ? `NPC_RESP_OKAY : `NPC_RESP_SLVERR;
		r.last = cnt_q == 8'd0;
		b.resp = err_q ? `NPC_RESP_SLVERR : `NPC_RESP_OKAY;
	end

	// ****************************************
	// transaction FSM
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SRAM_IDLE;
		end else begin
			case (state)
				SRAM_IDLE: begin
					if (aw_valid || ar_valid) begin
						idx_q <= req.addr[`NPC_ADDR_W-1:OFS_W];
						cnt_q <= req.len;
						bad_q <= req_bad;
						err_q <= req_bad;
						state <= aw_valid ? SRAM_WRITE : SRAM_READ;
					end
				end
				SRAM_READ: begin
					// beat holds until taken
					if (r_fire) begin
						if (cnt_q == 8'd0) begin
							state <= SRAM_IDLE;
						end else begin
							idx_q <= idx_q + IDX_W'(1);
							cnt_q <= cnt_q - 8'd1;
						end
					end
				end
				SRAM_WRITE: begin
					if (w_fire) begin
						idx_q <= idx_q + IDX_W'(1);
						cnt_q <= cnt_q - 8'd1;
						// out of range beat, or wlast off the counted end
						if (!beat_ok || (w.last != (cnt_q == 8'd0)))
							err_q <= 1'b1;
						if (cnt_q == 8'd0)
							state <= SRAM_RESP;
					end
				end
				SRAM_RESP: begin
					if (b_ready)
						state <= SRAM_IDLE;
				end
				default: state <= SRAM_IDLE;
			endcase
		end
	end

	// ****************************************
	// array write
	// ****************************************

	// byte merge, bad beats dropped
	always_ff @(posedge clk) begin
		if (w_fire && beat_ok) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (w.strb[i])
					mem[idx_q[MEM_AW-1:0]][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* chan_slice.sv */
`default_nettype none
`timescale 1ns/1ps

module chan_slice #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	// head drives the output, tail catches the skid beat
	payload_t   head_q;
	payload_t   tail_q;
	logic [1:0] cnt_q;
	logic [1:0] cnt_nxt;
	logic       push;
	logic       pop;

	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_valid = cnt_q != 2'd0;
	assign out_data  = head_q;

	// occupancy after this edge
	always_comb begin
		cnt_nxt = cnt_q;
		if (push && !pop)
			cnt_nxt = cnt_q + 2'd1;
		else if (pop && !push)
			cnt_nxt = cnt_q - 2'd1;
	end

	// ready comes from a flop, no path from out_ready
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q    <= 2'd0;
			in_ready <= 1'b0;
		end else begin
			cnt_q    <= cnt_nxt;
			in_ready <= cnt_nxt != 2'd2;
		end
	end

	// entries
	always_ff @(posedge clk) begin
		// empty, or one leaving while one arrives
		if (push && (cnt_q == 2'd0 || (cnt_q == 2'd1 && pop)))
			head_q <= in_data;
		else if (pop && cnt_q == 2'd2)
			head_q <= tail_q;
		// head busy, park the new beat
		if (push && cnt_q == 2'd1 && !pop)
			tail_q <= in_data;
	end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter import npc_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// fetch read port
	input  mem_addr_t fetch_ar,
	input  logic      fetch_ar_valid,
	output logic      fetch_ar_ready,
	output mem_r_t    fetch_r,
	output logic      fetch_r_valid,
	input  logic      fetch_r_ready,
	// load-store read port
	input  mem_addr_t lsu_ar,
	input  logic      lsu_ar_valid,
	output logic      lsu_ar_ready,
	output mem_r_t    lsu_r,
	output logic      lsu_r_valid,
	input  logic      lsu_r_ready,
	// load-store write port
	input  mem_addr_t lsu_aw,
	input  logic      lsu_aw_valid,
	output logic      lsu_aw_ready,
	input  mem_w_t    lsu_w,
	input  logic      lsu_w_valid,
	output logic      lsu_w_ready,
	output mem_b_t    lsu_b,
	output logic      lsu_b_valid,
	input  logic      lsu_b_ready,
	// slave side
	output mem_addr_t mem_ar,
	output logic      mem_ar_valid,
	input  logic      mem_ar_ready,
	input  mem_r_t    mem_r,
	input  logic      mem_r_valid,
	output logic      mem_r_ready,
	output mem_addr_t mem_aw,
	output logic      mem_aw_valid,
	input  logic      mem_aw_ready,
	output mem_w_t    mem_w,
	output logic      mem_w_valid,
	input  logic      mem_w_ready,
	input  mem_b_t    mem_b,
	input  logic      mem_b_valid,
	output logic      mem_b_ready
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_GRANT,
		ARB_DATA
	} arb_state_t;

	arb_state_t state;
	// read owner, 1 means load-store
	logic       owner_lsu;
	// port served by the last ar transfer
	logic       last_lsu;
	logic       pick_lsu;
	logic       granted;
	logic       in_data;

	assign granted = state == ARB_GRANT;
	assign in_data = state == ARB_DATA;

	// ****************************************
	// round robin pick
	// ****************************************

	// on a tie the port not served last wins
	always_comb begin
		if (fetch_ar_valid && lsu_ar_valid)
			pick_lsu = !last_lsu;
		else
			pick_lsu = lsu_ar_valid;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ARB_IDLE;
			owner_lsu <= 1'b0;
			// so fetch wins the first tie
			last_lsu  <= 1'b1;
		end else begin
			case (state)
				ARB_IDLE: begin
					// grant is registered, request goes out next cycle
					if (fetch_ar_valid || lsu_ar_valid) begin
						state     <= ARB_GRANT;
						owner_lsu <= pick_lsu;
					end
				end
				ARB_GRANT: begin
					if (mem_ar_valid && mem_ar_ready) begin
						state    <= ARB_DATA;
						last_lsu <= owner_lsu;
					end
				end
				ARB_DATA: begin
					// hold the owner until the last beat leaves
					if (mem_r_valid && mem_r_ready && mem_r.last)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// ****************************************
	// read steering
	// ****************************************

	assign mem_ar         = owner_lsu ? lsu_ar : fetch_ar;
	assign mem_ar_valid   = granted && (owner_lsu ? lsu_ar_valid : fetch_ar_valid);
	assign fetch_ar_ready = granted && !owner_lsu && mem_ar_ready;
	assign lsu_ar_ready   = granted && owner_lsu && mem_ar_ready;

	// beat payload goes to both, valid only to the owner
	assign fetch_r       = mem_r;
	assign lsu_r         = mem_r;
	assign fetch_r_valid = in_data && !owner_lsu && mem_r_valid;
	assign lsu_r_valid   = in_data && owner_lsu && mem_r_valid;
	assign mem_r_ready   = in_data && (owner_lsu ? lsu_r_ready : fetch_r_ready);

	// ****************************************
	// write path, load-store only
	// ****************************************

	assign mem_aw       = lsu_aw;
	assign mem_aw_valid = lsu_aw_valid;
	assign lsu_aw_ready = mem_aw_ready;
	assign mem_w        = lsu_w;
	assign mem_w_valid  = lsu_w_valid;
	assign lsu_w_ready  = mem_w_ready;
	assign lsu_b        = mem_b;
	assign lsu_b_valid  = mem_b_valid;
	assign mem_b_ready  = lsu_b_ready;

endmodule

`default_nettype wire

/* npc_mem.f */
+incdir+.
npc_mem_pkg.sv
chan_slice.sv
mem_arbiter.sv
axi_sram.sv
npc_mem.sv
npc_mem_properties.sv
npc_mem_checker.sv
tb_npc_mem.sv

/* npc_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module npc_mem import npc_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// fetch read port
	input  mem_addr_t fetch_ar,
	input  logic      fetch_ar_valid,
	output logic      fetch_ar_ready,
	output mem_r_t    fetch_r,
	output logic      fetch_r_valid,
	input  logic      fetch_r_ready,
	// load-store port
	input  mem_addr_t lsu_ar,
	input  logic      lsu_ar_valid,
	output logic      lsu_ar_ready,
	output mem_r_t    lsu_r,
	output logic      lsu_r_valid,
	input  logic      lsu_r_ready,
	input  mem_addr_t lsu_aw,
	input  logic      lsu_aw_valid,
	output logic      lsu_aw_ready,
	input  mem_w_t    lsu_w,
	input  logic      lsu_w_valid,
	output logic      lsu_w_ready,
	output mem_b_t    lsu_b,
	output logic      lsu_b_valid,
	input  logic      lsu_b_ready
);

	// ****************************************
	// arbiter to slices
	// ****************************************
	mem_addr_t mem_ar;
	logic      mem_ar_valid;
	logic      mem_ar_ready;
	mem_addr_t mem_aw;
	logic      mem_aw_valid;
	logic      mem_aw_ready;
	mem_w_t    mem_w;
	logic      mem_w_valid;
	logic      mem_w_ready;

	// slices to sram
	mem_addr_t s_ar;
	logic      s_ar_valid;
	logic      s_ar_ready;
	mem_addr_t s_aw;
	logic      s_aw_valid;
	logic      s_aw_ready;
	mem_w_t    s_w;
	logic      s_w_valid;
	logic      s_w_ready;

	// sram responses, straight back to the arbiter
	mem_r_t    mem_r;
	logic      mem_r_valid;
	logic      mem_r_ready;
	mem_b_t    mem_b;
	logic      mem_b_valid;
	logic      mem_b_ready;

	mem_arbiter arbiter (
		.clk            (clk),
		.rst            (rst),
		.fetch_ar       (fetch_ar),
		.fetch_ar_valid (fetch_ar_valid),
		.fetch_ar_ready (fetch_ar_ready),
		.fetch_r        (fetch_r),
		.fetch_r_valid  (fetch_r_valid),
		.fetch_r_ready  (fetch_r_ready),
		.lsu_ar         (lsu_ar),
		.lsu_ar_valid   (lsu_ar_valid),
		.lsu_ar_ready   (lsu_ar_ready),
		.lsu_r          (lsu_r),
		.lsu_r_valid    (lsu_r_valid),
		.lsu_r_ready    (lsu_r_ready),
		.lsu_aw         (lsu_aw),
		.lsu_aw_valid   (lsu_aw_valid),
		.lsu_aw_ready   (lsu_aw_ready),
		.lsu_w          (lsu_w),
		.lsu_w_valid    (lsu_w_valid),
		.lsu_w_ready    (lsu_w_ready),
		.lsu_b          (lsu_b),
		.lsu_b_valid    (lsu_b_valid),
		.lsu_b_ready    (lsu_b_ready),
		.mem_ar         (mem_ar),
		.mem_ar_valid   (mem_ar_valid),
		.mem_ar_ready   (mem_ar_ready),
		.mem_r          (mem_r),
		.mem_r_valid    (mem_r_valid),
		.mem_r_ready    (mem_r_ready),
		.mem_aw         (mem_aw),
		.mem_aw_valid   (mem_aw_valid),
		.mem_aw_ready   (mem_aw_ready),
		.mem_w          (mem_w),
		.mem_w_valid    (mem_w_valid),
		.mem_w_ready    (mem_w_ready),
		.mem_b          (mem_b),
		.mem_b_valid    (mem_b_valid),
		.mem_b_ready    (mem_b_ready)
	);

	// ****************************************
	// request slices
	// ****************************************
	chan_slice #(.payload_t(mem_addr_t)) ar_slice (
		.clk       (clk),
		.rst       (rst),
		.in_data   (mem_ar),
		.in_valid  (mem_ar_valid),
		.in_ready  (mem_ar_ready),
		.out_data  (s_ar),
		.out_valid (s_ar_valid),
		.out_ready (s_ar_ready)
	);

	chan_slice #(.payload_t(mem_addr_t)) aw_slice (
		.clk       (clk),
		.rst       (rst),
		.in_data   (mem_aw),
		.in_valid  (mem_aw_valid),
		.in_ready  (mem_aw_ready),
		.out_data  (s_aw),
		.out_valid (s_aw_valid),
		.out_ready (s_aw_ready)
	);

	chan_slice #(.payload_t(mem_w_t)) w_slice (
		.clk       (clk),
		.rst       (rst),
		.in_data   (mem_w),
		.in_valid  (mem_w_valid),
		.in_ready  (mem_w_ready),
		.out_data  (s_w),
		.out_valid (s_w_valid),
		.out_ready (s_w_ready)
	);

	axi_sram sram (
		.clk      (clk),
		.rst      (rst),
		.ar       (s_ar),
		.ar_valid (s_ar_valid),
		.ar_ready (s_ar_ready),
		.r        (mem_r),
		.r_valid  (mem_r_valid),
		.r_ready  (mem_r_ready),
		.aw       (s_aw),
		.aw_valid (s_aw_valid),
		.aw_ready (s_aw_ready),
		.w        (s_w),
		.w_valid  (s_w_valid),
		.w_ready  (s_w_ready),
		.b        (mem_b),
		.b_valid  (mem_b_valid),
		.b_ready  (mem_b_ready)
	);

endmodule

`default_nettype wire

/* npc_mem_checker.sv */
`default_nettype none
`timescale 1ns/1ps

`include "npc_mem_params.svh"

module npc_mem_checker import npc_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  mem_addr_t fetch_ar,
	input  logic      fetch_ar_valid,
	input  logic      fetch_ar_ready,
	input  mem_r_t    fetch_r,
	input  logic      fetch_r_valid,
	input  logic      fetch_r_ready,
	input  mem_addr_t lsu_ar,
	input  logic      lsu_ar_valid,
	input  logic      lsu_ar_ready,
	input  mem_r_t    lsu_r,
	input  logic      lsu_r_valid,
	input  logic      lsu_r_ready,
	input  mem_addr_t lsu_aw,
	input  logic      lsu_aw_valid,
	input  logic      lsu_aw_ready,
	input  mem_w_t    lsu_w,
	input  logic      lsu_w_valid,
	input  logic      lsu_w_ready,
	input  mem_b_t    lsu_b,
	input  logic      lsu_b_valid,
	input  logic      lsu_b_ready,
	output int        errors,
	output int        checks
);

	localparam int IDX_W  = `NPC_ADDR_W - 3;
	localparam int MEM_AW = $clog2(`NPC_SRAM_WORDS);

	// ****************************************
	// shadow state
	// ****************************************

	logic [`NPC_DATA_W-1:0] shadow [`NPC_SRAM_WORDS];
	// open read burst per port, index 1 is load-store
	logic             rd_open [2];
	logic [IDX_W-1:0] rd_idx [2];
	logic [7:0]       rd_len [2];
	logic [7:0]       rd_beat [2];
	// next write beat word
	logic [IDX_W-1:0] wr_idx;
	logic [1:0]       exp_b_q [$];
	// round robin model
	logic             last_lsu;
	logic             tie_open;
	logic             tie_exp_lsu;
	logic             wait_f;
	logic             wait_l;

	initial begin
		errors = 0;
		checks = 0;
	end

	// expected {resp, data} for one word index
	function automatic logic [`NPC_DATA_W+1:0] ref_beat(input logic [IDX_W-1:0] idx);
		if (idx >= IDX_W'(`NPC_SRAM_WORDS))
			return {`NPC_RESP_SLVERR, `NPC_DATA_W'(0)};
		return {`NPC_RESP_OKAY, shadow[idx[MEM_AW-1:0]]};
	endfunction

	task automatic open_read(input logic port_lsu, input mem_addr_t a);
		rd_open[port_lsu] = 1'b1;
		rd_idx[port_lsu]  = a.addr[`NPC_ADDR_W-1:3];
		rd_len[port_lsu]  = a.len;
		rd_beat[port_lsu] = 8'd0;
		// a fresh tie names its winner
		if (tie_open) begin
			checks++;
			if (port_lsu != tie_exp_lsu) begin
				$display("read grant went to the wrong port after a tie");
				errors++;
			end
			tie_open = 1'b0;
		end
		last_lsu = port_lsu;
	endtask

	task automatic check_beat(input logic port_lsu, input mem_r_t r);
		logic [`NPC_DATA_W+1:0] exp;
		logic                   exp_last;
		string                  name;
		name = port_lsu ? "lsu_r" : "fetch_r";
		if (!rd_open[port_lsu]) begin
			$display("read beat on %s with no open burst", name);
			errors++;
			return;
		end
		exp      = ref_beat(rd_idx[port_lsu] + IDX_W'(rd_beat[port_lsu]));
		exp_last = rd_beat[port_lsu] == rd_len[port_lsu];
		checks++;
		if (r.data !== exp[`NPC_DATA_W-1:0]) begin
			$display("Error: %s.data got %h expected %h", name, r.data, exp[`NPC_DATA_W-1:0]);
			errors++;
		end
		if (r.resp !== exp[`NPC_DATA_W+1:`NPC_DATA_W]) begin
			$display("Error: %s.resp got %h expected %h", name, r.resp,
				exp[`NPC_DATA_W+1:`NPC_DATA_W]);
			errors++;
		end
		if (r.last !== exp_last) begin
			$display("Error: %s.last got %h expected %h", name, r.last, exp_last);
			errors++;
		end
		// burst ends on the counted beat
		if (exp_last)
			rd_open[port_lsu] = 1'b0;
		else
			rd_beat[port_lsu] = rd_beat[port_lsu] + 8'd1;
	endtask

	// ****************************************
	// watcher
	// ****************************************

	always @(posedge clk) begin
		logic             err;
		logic [IDX_W-1:0] idx;
		logic [1:0]       exp_resp;
		if (rst) begin
			rd_open[0] = 1'b0;
			rd_open[1] = 1'b0;
			last_lsu   = 1'b1;
			tie_open   = 1'b0;
			wait_f     = 1'b0;
			wait_l     = 1'b0;
		end else begin
			// both raised in the same cycle, neither already waiting
			if (fetch_ar_valid && lsu_ar_valid && !wait_f && !wait_l) begin
				tie_open    = 1'b1;
				tie_exp_lsu = !last_lsu;
			end
			wait_f = fetch_ar_valid && !fetch_ar_ready;
			wait_l = lsu_ar_valid && !lsu_ar_ready;
			if (fetch_ar_valid && fetch_ar_ready)
				open_read(1'b0, fetch_ar);
			if (lsu_ar_valid && lsu_ar_ready)
				open_read(1'b1, lsu_ar);
			if (fetch_r_valid && fetch_r_ready)
				check_beat(1'b0, fetch_r);
			if (lsu_r_valid && lsu_r_ready)
				check_beat(1'b1, lsu_r);
			// any beat out of range fails the whole burst
			if (lsu_aw_valid && lsu_aw_ready) begin
				wr_idx = lsu_aw.addr[`NPC_ADDR_W-1:3];
				err    = 1'b0;
				for (int i = 0; i <= int'(lsu_aw.len); i++) begin
					idx = wr_idx + IDX_W'(i);
					if (idx >= IDX_W'(`NPC_SRAM_WORDS))
						err = 1'b1;
				end
				exp_b_q.push_back(err ? `NPC_RESP_SLVERR : `NPC_RESP_OKAY);
			end
			// byte merge into the shadow
			if (lsu_w_valid && lsu_w_ready) begin
				if (wr_idx < IDX_W'(`NPC_SRAM_WORDS)) begin
					for (int i = 0; i < 8; i++) begin
						if (lsu_w.strb[i])
							shadow[wr_idx[MEM_AW-1:0]][8*i +: 8] = lsu_w.data[8*i +: 8];
					end
				end
				wr_idx = wr_idx + IDX_W'(1);
			end
			if (lsu_b_valid && lsu_b_ready) begin
				checks++;
				if (exp_b_q.size() == 0) begin
					$display("write response with no write burst behind it");
					errors++;
				end else begin
					exp_resp = exp_b_q.pop_front();
					if (lsu_b.resp !== exp_resp) begin
						$display("Error: lsu_b.resp got %h expected %h", lsu_b.resp, exp_resp);
						errors++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* npc_mem_params.svh */
`ifndef NPC_MEM_PARAMS_SVH
`define NPC_MEM_PARAMS_SVH

// ****************************************
// bus widths
// ****************************************

// byte address width on every address channel
`define NPC_ADDR_W 32
// one beat is one 64-bit word
`define NPC_DATA_W 64

// ****************************************
// sram and responses
// ****************************************

// depth in 8-byte words
`define NPC_SRAM_WORDS 256
`define NPC_RESP_OKAY 2'd0
`define NPC_RESP_SLVERR 2'd2

`endif

/* npc_mem_pkg.sv */
`default_nettype none

`include "npc_mem_params.svh"

package npc_mem_pkg;

	// ****************************************
	// fixed burst attributes
	// ****************************************

	// only 8-byte beats
	localparam logic [2:0] SIZE_8B = 3'd3;
	// only incrementing bursts
	localparam logic [1:0] BURST_INCR = 2'b01;

	// ****************************************
	// channel payloads
	// ****************************************

	// shared by ar and aw
	typedef struct packed {
		logic [`NPC_ADDR_W-1:0] addr;
		// beats minus one
		logic [7:0]             len;
		logic [2:0]             size;
		logic [1:0]             burst;
	} mem_addr_t;

	// read beat
	typedef struct packed {
		logic [`NPC_DATA_W-1:0] data;
		logic [1:0]             resp;
		logic                   last;
	} mem_r_t;

	// write beat, one strobe bit per byte
	typedef struct packed {
		logic [`NPC_DATA_W-1:0]   data;
		logic [`NPC_DATA_W/8-1:0] strb;
		logic                     last;
	} mem_w_t;

	// write response
	typedef struct packed {
		logic [1:0] resp;
	} mem_b_t;

endpackage

`default_nettype wire

/* npc_mem_properties.sv */
`default_nettype none
`timescale 1ns/1ps

module npc_mem_properties import npc_mem_pkg::*; (
	input logic      clk,
	input logic      rst,
	input mem_addr_t fetch_ar,
	input logic      fetch_ar_valid,
	input logic      fetch_ar_ready,
	input logic      fetch_r_valid,
	input mem_addr_t lsu_ar,
	input logic      lsu_ar_valid,
	input logic      lsu_ar_ready,
	input logic      lsu_r_valid,
	input mem_addr_t lsu_aw,
	input logic      lsu_aw_valid,
	input logic      lsu_aw_ready,
	input mem_w_t    lsu_w,
	input logic      lsu_w_valid,
	input logic      lsu_w_ready,
	input logic      lsu_b_valid,
	input logic      lsu_b_ready
);

	// finished w bursts still owed a response
	logic [3:0] b_owed;

	always_ff @(posedge clk) begin
		if (rst)
			b_owed <= 4'd0;
		else
			b_owed <= b_owed + 4'(lsu_w_valid && lsu_w_ready && lsu_w.last)
				- 4'(lsu_b_valid && lsu_b_ready);
	end

	// ****************************************
	// request channels hold until taken
	// ****************************************
	a_fetch_ar_hold: assert property (@(posedge clk) disable iff (rst)
		fetch_ar_valid && !fetch_ar_ready |=> fetch_ar_valid && $stable(fetch_ar))
		else $error("fetch_ar changed before ready");
	a_lsu_ar_hold: assert property (@(posedge clk) disable iff (rst)
		lsu_ar_valid && !lsu_ar_ready |=> lsu_ar_valid && $stable(lsu_ar))
		else $error("lsu_ar changed before ready");
	a_lsu_aw_hold: assert property (@(posedge clk) disable iff (rst)
		lsu_aw_valid && !lsu_aw_ready |=> lsu_aw_valid && $stable(lsu_aw))
		else $error("lsu_aw changed before ready");
	a_lsu_w_hold: assert property (@(posedge clk) disable iff (rst)
		lsu_w_valid && !lsu_w_ready |=> lsu_w_valid && $stable(lsu_w))
		else $error("lsu_w changed before ready");

	// quiet responses in reset, after the first edge
	a_no_resp_in_rst: assert property (@(posedge clk)
		rst && $past(rst) |-> !fetch_r_valid && !lsu_r_valid && !lsu_b_valid)
		else $error("response valid during reset");

	a_b_after_w: assert property (@(posedge clk) disable iff (rst)
		lsu_b_valid |-> b_owed != 4'd0)
		else $error("write response without a finished w burst");

endmodule

bind npc_mem npc_mem_properties props (
	.clk            (clk),
	.rst            (rst),
	.fetch_ar       (fetch_ar),
	.fetch_ar_valid (fetch_ar_valid),
	.fetch_ar_ready (fetch_ar_ready),
	.fetch_r_valid  (fetch_r_valid),
	.lsu_ar         (lsu_ar),
	.lsu_ar_valid   (lsu_ar_valid),
	.lsu_ar_ready   (lsu_ar_ready),
	.lsu_r_valid    (lsu_r_valid),
	.lsu_aw         (lsu_aw),
	.lsu_aw_valid   (lsu_aw_valid),
	.lsu_aw_ready   (lsu_aw_ready),
	.lsu_w          (lsu_w),
	.lsu_w_valid    (lsu_w_valid),
	.lsu_w_ready    (lsu_w_ready),
	.lsu_b_valid    (lsu_b_valid),
	.lsu_b_ready    (lsu_b_ready)
);

`default_nettype wire

/* tb_npc_mem.sv */
`default_nettype none
`timescale 1ns/1ps

`include "npc_mem_params.svh"

module tb_npc_mem import npc_mem_pkg::*; ();

	// beats and bursts of the sequence below
	localparam int PLANNED_BEATS  = 185;
	localparam int PLANNED_BURSTS = 94;
	// stalls double the beats, each burst adds its latency
	localparam int CYCLE_LIMIT = 2 * PLANNED_BEATS + 12 * PLANNED_BURSTS + 200;

	logic      clk = 1'b0;
	logic      rst;
	mem_addr_t fetch_ar;
	logic      fetch_ar_valid;
	logic      fetch_ar_ready;
	mem_r_t    fetch_r;
	logic      fetch_r_valid;
	logic      fetch_r_ready;
	mem_addr_t lsu_ar;
	logic      lsu_ar_valid;
	logic      lsu_ar_ready;
	mem_r_t    lsu_r;
	logic      lsu_r_valid;
	logic      lsu_r_ready;
	mem_addr_t lsu_aw;
	logic      lsu_aw_valid;
	logic      lsu_aw_ready;
	mem_w_t    lsu_w;
	logic      lsu_w_valid;
	logic      lsu_w_ready;
	mem_b_t    lsu_b;
	logic      lsu_b_valid;
	logic      lsu_b_ready;
	int        errors;
	int        checks;
	int        cycles = 0;
	int        seed;

	always #5 clk = !clk;

	npc_mem dut (.*);

	npc_mem_checker chk (.*);

	// ****************************************
	// master drivers
	// ****************************************

	function automatic mem_addr_t make_addr(input int word, input int len);
		mem_addr_t a;
		a.addr  = 32'(word) << 3;
		a.len   = 8'(len);
		a.size  = SIZE_8B;
		a.burst = BURST_INCR;
		return a;
	endfunction

	task automatic read_burst(input logic port_lsu, input int word, input int len);
		logic done;
		done = 1'b0;
		@(posedge clk);
		#1;
		if (port_lsu) begin
			lsu_ar       = make_addr(word, len);
			lsu_ar_valid = 1'b1;
		end else begin
			fetch_ar       = make_addr(word, len);
			fetch_ar_valid = 1'b1;
		end
		do @(posedge clk); while (!(port_lsu ? lsu_ar_ready : fetch_ar_ready));
		#1;
		fetch_ar_valid = port_lsu ? fetch_ar_valid : 1'b0;
		lsu_ar_valid   = port_lsu ? 1'b0 : lsu_ar_valid;
		// random rready until the last beat
		while (!done) begin
			if (port_lsu)
				lsu_r_ready = ($random(seed) % 4) != 0;
			else
				fetch_r_ready = ($random(seed) % 4) != 0;
			@(posedge clk);
			if (port_lsu && lsu_r_valid && lsu_r_ready && lsu_r.last)
				done = 1'b1;
			if (!port_lsu && fetch_r_valid && fetch_r_ready && fetch_r.last)
				done = 1'b1;
			#1;
		end
		if (port_lsu)
			lsu_r_ready = 1'b0;
		else
			fetch_r_ready = 1'b0;
	endtask

	task automatic write_burst(input int word, input int len, input logic rand_strb);
		mem_w_t beat;
		@(posedge clk);
		#1;
		lsu_aw       = make_addr(word, len);
		lsu_aw_valid = 1'b1;
		do @(posedge clk); while (!lsu_aw_ready);
		#1;
		lsu_aw_valid = 1'b0;
		for (int i = 0; i <= len; i++) begin
			// random gap before the beat
			while (($random(seed) % 3) == 0) begin
				@(posedge clk);
				#1;
			end
			beat.data   = {$random(seed), $random(seed)};
			beat.strb   = rand_strb ? 8'($random(seed)) : 8'hff;
			beat.last   = i == len;
			lsu_w       = beat;
			lsu_w_valid = 1'b1;
			do @(posedge clk); while (!lsu_w_ready);
			#1;
			lsu_w_valid = 1'b0;
		end
		// bready stays high
		do @(posedge clk); while (!lsu_b_valid);
	endtask

	// ****************************************
	// timeout
	// ****************************************

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("test failed");
			$finish;
		end
	end

	// ****************************************
	// test sequence
	// ****************************************

	initial begin
		seed           = 32'h0398616a;
		rst            = 1'b1;
		fetch_ar       = '0;
		fetch_ar_valid = 1'b0;
		fetch_r_ready  = 1'b0;
		lsu_ar         = '0;
		lsu_ar_valid   = 1'b0;
		lsu_r_ready    = 1'b0;
		lsu_aw         = '0;
		lsu_aw_valid   = 1'b0;
		lsu_w          = '0;
		lsu_w_valid    = 1'b0;
		lsu_b_ready    = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// full-strobe single words
		for (int i = 0; i < 16; i++)
			write_burst(i, 0, 1'b0);
		// same-cycle reads before any other read, fetch wins first
		for (int i = 0; i < 3; i++) begin
			// a lone fetch read hands the next tie to load-store
			if (i == 1)
				read_burst(1'b0, 15, 0);
			fork
				read_burst(1'b0, 2 * i, 0);
				read_burst(1'b1, 2 * i + 1, 0);
			join
		end
		for (int i = 0; i < 8; i++) begin
			read_burst(1'b0, i, 0);
			read_burst(1'b1, i + 8, 0);
		end

		// partial strobes
		for (int i = 0; i < 8; i++)
			write_burst(i, 0, 1'b1);
		for (int i = 0; i < 8; i++) begin
			read_burst(1'b0, i, 0);
			read_burst(1'b1, i, 0);
		end

		// bursts of 1 to 8 beats
		for (int len = 0; len < 8; len++) begin
			write_burst(32 + 8 * len, len, 1'b0);
			read_burst(1'b0, 32 + 8 * len, len);
			read_burst(1'b1, 32 + 8 * len, len);
		end

		// out of range, word 300 aliases 44 in the array
		// known contents under the alias first
		write_burst(44, 0, 1'b0);
		write_burst(300, 0, 1'b0);
		write_burst(254, 3, 1'b0);
		read_burst(1'b1, 254, 3);
		read_burst(1'b0, 300, 0);
		read_burst(1'b1, 44, 0);
		read_burst(1'b0, 0, 1);

		repeat (5) @(posedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
